// File: common/accel_core_defs.svh
// accel core dot-product unit parameters
// operand, accumulator and result FIFO sizing shared by RTL and testbench

`ifndef ACCEL_CORE_DEFS_SVH
`define ACCEL_CORE_DEFS_SVH

// signed operand width in bits
`define WEIGHT_WIDTH 8

// accumulator and result width, wraps on overflow
`define ACC_WIDTH 24

// result slots in the output FIFO
// also the number of input credits the producer starts with
`define OUT_FIFO_DEPTH 4

// credit counters must hold the full FIFO depth
`define CREDIT_WIDTH ($clog2(`OUT_FIFO_DEPTH + 1))

`endif

// File: common/accel_core_pkg.sv
// accel core shared types
// vector widths for operands, products, results and credits,
// plus the output state encoding of the result FIFO

`default_nettype none

`include "accel_core_defs.svh"

package accel_core_pkg;

    // one signed weight or activation
    typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;

    // full precision lane product
    typedef logic signed [2*`WEIGHT_WIDTH-1:0] product_t;

    // running sum and FIFO result
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    // credit and occupancy counts
    typedef logic [`CREDIT_WIDTH-1:0] credit_t;

    // result FIFO output state
    // BLOCKED holds data but has no output credit
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        SEND    = 2'b01,
        BLOCKED = 2'b10
    } fifo_state_e;

endpackage

`default_nettype wire

// File: booth_mul/accel_core_booth_pipeline.sv
// signed radix-2 Booth multiplier, fully pipelined
// one setup stage, then one stage per multiplier bit
// valid and last travel alongside the data, one product per cycle

`default_nettype none

`include "accel_core_defs.svh"

module accel_core_booth_pipeline (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      in_last,
    input  accel_core_pkg::weight_t   mu,
    input  accel_core_pkg::weight_t   qu,
    output accel_core_pkg::product_t  prod,
    output logic                      prod_valid,
    output logic                      prod_last
);

    localparam int W = `WEIGHT_WIDTH;

    // {A (W+1 bits), Q (W bits), Q-1}
    // A carries an extra bit so that -min * -min does not overflow
    logic [2*W+1:0] aqq [0:W];
    logic [W-1:0]   mcand [0:W-1];
    logic           vld_q [0:W];
    logic           last_q [0:W];

    // setup stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aqq[0]    <= '0;
            mcand[0]  <= '0;
            vld_q[0]  <= 1'b0;
            last_q[0] <= 1'b0;
        end else begin
            aqq[0]    <= {{(W+1){1'b0}}, qu, 1'b0};
            mcand[0]  <= mu;
            vld_q[0]  <= in_valid;
            last_q[0] <= in_valid & in_last;
        end
    end

    // iteration stages
    for (genvar i = 0; i < W; i++) begin : g_stage
        logic [W:0] m_ext;
        logic [W:0] a_cur;
        logic [W:0] a_new;

        assign m_ext = {mcand[i][W-1], mcand[i]};
        assign a_cur = aqq[i][2*W+1:W+1];

        // Q0 and Q-1 pick add, subtract or keep
        always_comb begin
            case (aqq[i][1:0])
                2'b01:   a_new = a_cur + m_ext;
                2'b10:   a_new = a_cur - m_ext;
                default: a_new = a_cur;
            endcase
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                aqq[i+1]    <= '0;
                vld_q[i+1]  <= 1'b0;
                last_q[i+1] <= 1'b0;
            end else begin
                // arithmetic shift right of the whole word, Q-1 drops out
                aqq[i+1]    <= {a_new[W], a_new, aqq[i][W:1]};
                vld_q[i+1]  <= vld_q[i];
                last_q[i+1] <= last_q[i];
            end
        end

        // multiplicand is only needed up to the last iteration
        if (i < W-1) begin : g_mcand
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    mcand[i+1] <= '0;
                end else begin
                    mcand[i+1] <= mcand[i];
                end
            end
        end
    end

    // product sits below the redundant sign bit of A
    assign prod       = aqq[W][2*W:1];
    assign prod_valid = vld_q[W];
    assign prod_last  = last_q[W];

endmodule

`default_nettype wire

// File: source/accel_core_dot_combiner.sv
// dot-product combiner
// adds the two lane products and accumulates them over a vector,
// emitting the total as a one-cycle write strobe when last arrives

`default_nettype none

module accel_core_dot_combiner (
    input  logic                      clk,
    input  logic                      rst,
    input  accel_core_pkg::product_t  prod0,
    input  accel_core_pkg::product_t  prod1,
    input  logic                      prod_valid,
    input  logic                      prod_last,
    output accel_core_pkg::acc_t      res_data,
    output logic                      res_valid
);

    accel_core_pkg::acc_t prod0_ext;
    accel_core_pkg::acc_t prod1_ext;
    accel_core_pkg::acc_t pair_sum;
    accel_core_pkg::acc_t acc;
    accel_core_pkg::acc_t acc_sum;
    logic                 vec_done;

    // sign extend both lanes to the accumulator width
    always_comb begin
        prod0_ext = accel_core_pkg::acc_t'(prod0);
        prod1_ext = accel_core_pkg::acc_t'(prod1);
        pair_sum  = prod0_ext + prod1_ext;
    end

    // running sum including the current pair, wraps modulo 2^ACC_WIDTH
    assign acc_sum  = acc + pair_sum;
    assign vec_done = prod_valid & prod_last;

    // accumulator restarts from zero right after last,
    // so the next vector can follow with no gap cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (prod_valid) begin
            if (prod_last) begin
                acc <= '0;
            end else begin
                acc <= acc_sum;
            end
        end
    end

    // write strobe towards the result FIFO
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= vec_done;
        end
    end

    // total of the closed vector
    always_ff @(posedge clk) begin
        if (vec_done) begin
            res_data <= acc_sum;
        end
    end

endmodule

`default_nettype wire

// File: source/accel_core_result_fifo.sv
// result FIFO with credit flow control on both sides
// holds finished dot products until the consumer grants output credits;
// every result sent returns one input credit to the producer

`default_nettype none

`include "accel_core_defs.svh"

module accel_core_result_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  accel_core_pkg::acc_t  res_data,
    input  logic                  res_valid,
    input  logic                  out_credit,
    output accel_core_pkg::acc_t  out_data,
    output logic                  out_valid,
    output logic                  in_credit
);

    localparam int DEPTH = `OUT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam accel_core_pkg::credit_t CREDIT_MAX = '1;

    accel_core_pkg::acc_t        mem [0:DEPTH-1];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    accel_core_pkg::credit_t     fill;
    accel_core_pkg::credit_t     fill_next;
    accel_core_pkg::credit_t     out_cnt;
    accel_core_pkg::credit_t     out_cnt_next;
    accel_core_pkg::fifo_state_e state;
    accel_core_pkg::fifo_state_e state_next;
    logic                        send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // an incoming result can go straight out when the buffer is empty
    assign send = (out_cnt != '0) && ((fill != '0) || res_valid);

    assign fill_next = fill + accel_core_pkg::credit_t'(res_valid)
                            - accel_core_pkg::credit_t'(send);

    // output credits, saturating
    always_comb begin
        case ({out_credit, send})
            2'b10:   out_cnt_next = (out_cnt == CREDIT_MAX) ? out_cnt : out_cnt + 1'b1;
            2'b01:   out_cnt_next = out_cnt - 1'b1;
            default: out_cnt_next = out_cnt;
        endcase
    end

    always_comb begin
        if (send) begin
            state_next = accel_core_pkg::SEND;
        end else if (fill_next != '0) begin
            state_next = accel_core_pkg::BLOCKED;
        end else begin
            state_next = accel_core_pkg::IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            out_cnt <= '0;
            state   <= accel_core_pkg::IDLE;
        end else begin
            if (res_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill    <= fill_next;
            out_cnt <= out_cnt_next;
            state   <= state_next;
        end
    end

    // storage, slot is written even when bypassed to keep pointers aligned
    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem[wr_ptr] <= res_data;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data <= (fill == '0) ? res_data : mem[rd_ptr];
        end
    end

    // a pop frees one slot, which goes back to the producer
    assign out_valid = (state == accel_core_pkg::SEND);
    assign in_credit = (state == accel_core_pkg::SEND);

endmodule

`default_nettype wire

// File: source/accel_core_dot_unit.sv
// two-lane dot-product unit
// two Booth pipelines in lockstep feed a combiner that accumulates
// each vector; totals leave through a credit controlled result FIFO

`default_nettype none

module accel_core_dot_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic                     in_last,
    input  accel_core_pkg::weight_t  a0_weight,
    input  accel_core_pkg::weight_t  a0_act,
    input  accel_core_pkg::weight_t  a1_weight,
    input  accel_core_pkg::weight_t  a1_act,
    output logic                     in_credit,
    input  logic                     out_credit,
    output logic                     out_valid,
    output accel_core_pkg::acc_t     out_data
);

    accel_core_pkg::product_t prod0;
    accel_core_pkg::product_t prod1;
    logic                     prod_valid;
    logic                     prod_last;
    accel_core_pkg::acc_t     res_data;
    logic                     res_valid;

    // lane 0 carries the control for both lanes
    accel_core_booth_pipeline u_booth_lane0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .mu         (a0_weight),
        .qu         (a0_act),
        .prod       (prod0),
        .prod_valid (prod_valid),
        .prod_last  (prod_last)
    );

    accel_core_booth_pipeline u_booth_lane1 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .mu         (a1_weight),
        .qu         (a1_act),
        .prod       (prod1),
        .prod_valid (),
        .prod_last  ()
    );

    accel_core_dot_combiner u_combiner (
        .clk        (clk),
        .rst        (rst),
        .prod0      (prod0),
        .prod1      (prod1),
        .prod_valid (prod_valid),
        .prod_last  (prod_last),
        .res_data   (res_data),
        .res_valid  (res_valid)
    );

    accel_core_result_fifo u_result_fifo (
        .clk        (clk),
        .rst        (rst),
        .res_data   (res_data),
        .res_valid  (res_valid),
        .out_credit (out_credit),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

// File: tests/tb_accel_core_dot_unit.sv
// testbench for the two-lane dot-product unit
// producer and consumer credit models, a scoreboard and directed tests

`default_nettype none

`include "accel_core_defs.svh"

module tb_accel_core_dot_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W           = `WEIGHT_WIDTH;
    localparam int DEPTH       = `OUT_FIFO_DEPTH;
    localparam int OP_MAX      = 2 ** (W - 1) - 1;
    localparam int OP_MIN      = -(2 ** (W - 1));
    localparam int RESET_LEN   = 8;
    localparam int NUM_VECTORS = 9 + 12 + DEPTH + 16 + 5;
    localparam int MAX_PAIRS   = 9 + 12 * 16 + DEPTH * 3 + 16 * 2 + 27;
    // one cycle per pair plus 40 cycles of slack for every vector
    localparam int TIMEOUT_CYCLES = MAX_PAIRS + 40 * NUM_VECTORS + 2 * RESET_LEN;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    in_last;
    accel_core_pkg::weight_t a0_weight;
    accel_core_pkg::weight_t a0_act;
    accel_core_pkg::weight_t a1_weight;
    accel_core_pkg::weight_t a1_act;
    logic                    in_credit;
    logic                    out_credit;
    logic                    out_valid;
    accel_core_pkg::acc_t    out_data;

    // scoreboard and credit models
    accel_core_pkg::acc_t exp_q [$];
    accel_core_pkg::acc_t exp_val;
    integer               seed;
    string                test_name;
    int                   cyc = 0;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   vec_sum = 0;
    int                   prod_credits = DEPTH;
    int                   min_credits = DEPTH;
    int                   credits_out = 0;
    int                   grant_req = 0;
    int                   rx_count = 0;
    int                   ic_count = 0;
    bit                   auto_credit = 1'b0;

    // {a0_weight, a0_act, a1_weight, a1_act}
    int corners [0:8][0:3] = '{
        '{0, 0, 0, 0},
        '{OP_MAX, OP_MAX, 0, 0},
        '{OP_MIN, OP_MIN, 0, 0},
        '{OP_MIN, OP_MAX, OP_MAX, OP_MIN},
        '{OP_MIN, OP_MIN, OP_MIN, OP_MIN},
        '{OP_MAX, OP_MAX, OP_MAX, OP_MAX},
        '{-1, -1, 1, -1},
        '{OP_MIN, 1, 0, OP_MAX},
        '{5, -7, -3, 9}
    };

    accel_core_dot_unit u_accel_core_dot_unit (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .a0_weight  (a0_weight),
        .a0_act     (a0_act),
        .a1_weight  (a1_weight),
        .a1_act     (a1_act),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the DUT stopped delivering results", cyc);
        $display("FAIL: see errors above");
        $finish;
    end

    // consumer, grants on request or to match results still expected
    always @(posedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
        end else if (grant_req > 0 || (auto_credit && credits_out < exp_q.size())) begin
            out_credit <= 1'b1;
            credits_out = credits_out + 1;
            if (grant_req > 0) begin
                grant_req = grant_req - 1;
            end
        end else begin
            out_credit <= 1'b0;
        end
    end

    // outputs are checked at the falling edge where they are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit !== out_valid) begin
                errors++;
                $display("error in %s: in_credit and out_valid differ at cycle %0d",
                         test_name, cyc);
            end
            if (in_credit === 1'b1) begin
                prod_credits++;
                ic_count++;
            end
            if (out_valid === 1'b1) begin
                rx_count++;
                if (credits_out > 0) begin
                    credits_out--;
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error in %s: result %0d arrived with none expected",
                             test_name, out_data);
                end else begin
                    exp_val = exp_q.pop_front();
                    if (out_data !== exp_val) begin
                        errors++;
                        $display("[ERROR] %s: expected %0d, actual %0d",
                                 test_name, exp_val, out_data);
                    end
                end
            end
        end
    end

    function automatic int rand_operand();
        logic [31:0] r;
        r = $random(seed);
        return int'($signed(r[W-1:0]));
    endfunction

    function automatic int rand_len(input int max);
        logic [31:0] r;
        r = $random(seed);
        return 1 + int'(r[15:0]) % max;
    endfunction

    // producer, holds back a last pair until it owns an input credit
    task automatic send_pair(input int w0, input int x0, input int w1, input int x1,
                             input bit last);
        while (last && prod_credits <= 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_last  <= 1'b0;
        end
        @(posedge clk);
        in_valid  <= 1'b1;
        in_last   <= last;
        a0_weight <= accel_core_pkg::weight_t'(w0);
        a0_act    <= accel_core_pkg::weight_t'(x0);
        a1_weight <= accel_core_pkg::weight_t'(w1);
        a1_act    <= accel_core_pkg::weight_t'(x1);
        vec_sum = vec_sum + w0 * x0 + w1 * x1;
        if (last) begin
            exp_q.push_back(accel_core_pkg::acc_t'(vec_sum));
            vec_sum = 0;
            prod_credits--;
            if (prod_credits < min_credits) begin
                min_credits = prod_credits;
            end
        end
    endtask

    task automatic send_random_vector(input int len);
        for (int k = 0; k < len; k++) begin
            send_pair(rand_operand(), rand_operand(), rand_operand(), rand_operand(),
                      k == len - 1);
        end
    endtask

    task automatic stop_input();
        @(posedge clk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic grant_credit();
        @(negedge clk);
        grant_req++;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        // results in flight are lost, so the models start over
        @(negedge clk);
        exp_q.delete();
        vec_sum      = 0;
        prod_credits = DEPTH;
        credits_out  = 0;
        grant_req    = 0;
        auto_credit  = 1'b0;
        repeat (RESET_LEN - 1) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic finish_test(input int start_err);
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - start_err);
    endtask

    task automatic test_single_products();
        int start_err;
        int t0;
        test_name   = "single_products";
        start_err   = errors;
        auto_credit = 1'b1;
        for (int i = 0; i < 9; i++) begin
            send_pair(corners[i][0], corners[i][1], corners[i][2], corners[i][3], 1'b1);
            @(negedge clk);
            t0 = cyc;
            stop_input();
            @(negedge clk);
            while (out_valid !== 1'b1) begin
                @(negedge clk);
            end
            check_value("latency", W + 3, cyc - t0);
        end
        wait_drain();
        finish_test(start_err);
    endtask

    task automatic test_accumulation();
        int start_err;
        test_name   = "accumulation";
        start_err   = errors;
        auto_credit = 1'b1;
        for (int v = 0; v < 12; v++) begin
            send_random_vector(rand_len(16));
        end
        stop_input();
        wait_drain();
        finish_test(start_err);
    endtask

    task automatic test_backpressure();
        int start_err;
        int rx0;
        int ic0;
        test_name   = "backpressure";
        start_err   = errors;
        auto_credit = 1'b0;
        rx0 = rx_count;
        ic0 = ic_count;
        for (int v = 0; v < DEPTH; v++) begin
            send_random_vector(rand_len(3));
        end
        stop_input();
        repeat (W + 8) @(posedge clk);
        if (rx_count != rx0 || ic_count != ic0) begin
            errors++;
            $display("error in %s: results left the FIFO without output credits", test_name);
        end
        check_value("producer credits", 0, prod_credits);
        // credits trickle in, one result per credit
        for (int c = 0; c < DEPTH; c++) begin
            grant_credit();
            repeat (3) @(posedge clk);
        end
        wait_drain();
        check_value("results", DEPTH, rx_count - rx0);
        check_value("input credits", DEPTH, ic_count - ic0);
        check_value("producer credits", DEPTH, prod_credits);
        finish_test(start_err);
    endtask

    task automatic test_input_credits();
        int start_err;
        int rx0;
        test_name   = "input_credits";
        start_err   = errors;
        auto_credit = 1'b0;
        min_credits = prod_credits;
        rx0 = rx_count;
        fork
            begin
                for (int v = 0; v < 16; v++) begin
                    send_random_vector(rand_len(2));
                end
                stop_input();
            end
            begin
                repeat (16) begin
                    repeat (10) @(posedge clk);
                    grant_credit();
                end
            end
        join
        wait_drain();
        check_value("results", 16, rx_count - rx0);
        check_value("producer credits", DEPTH, prod_credits);
        // the producer must have run dry and never gone below zero
        check_value("lowest producer credits", 0, min_credits);
        finish_test(start_err);
    endtask

    task automatic test_reset();
        int start_err;
        int rx0;
        test_name   = "reset";
        start_err   = errors;
        auto_credit = 1'b0;
        // one result held in the FIFO and a partial sum in the combiner
        send_random_vector(3);
        for (int p = 0; p < 12; p++) begin
            send_pair(rand_operand(), rand_operand(), rand_operand(), rand_operand(), 1'b0);
        end
        apply_reset();
        rx0 = rx_count;
        // a credit with nothing new sent must not release stale data
        grant_credit();
        repeat (30) @(negedge clk);
        if (rx_count != rx0) begin
            errors++;
            $display("error in %s: out_valid rose after reset with no new vectors", test_name);
        end
        auto_credit = 1'b1;
        for (int v = 0; v < 3; v++) begin
            send_random_vector(rand_len(4));
        end
        stop_input();
        wait_drain();
        check_value("results", 3, rx_count - rx0);
        finish_test(start_err);
    endtask

    initial begin
        seed       = 32'hf172;
        test_name  = "reset_init";
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        a0_weight  = '0;
        a0_act     = '0;
        a1_weight  = '0;
        a1_act     = '0;
        out_credit = 1'b0;
        repeat (RESET_LEN) @(posedge clk);
        rst <= 1'b0;

        test_single_products();
        test_accumulation();
        test_backpressure();
        test_input_credits();
        test_reset();

        repeat (5) @(posedge clk);
        $display("%0d tests run, %0d results checked, %0d errors", tests_run, rx_count, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/accel_core_pkg.sv
booth_mul/accel_core_booth_pipeline.sv
source/accel_core_dot_combiner.sv
source/accel_core_result_fifo.sv
source/accel_core_dot_unit.sv
tests/tb_accel_core_dot_unit.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dot-product unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module tb_accel_core_dot_unit -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation did not build or run"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
